// ==== include/dcache_macros.svh ====
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

//////////////////////////////
// address and data widths
//////////////////////////////
`define DC_ADDR_W      32  // byte address.
`define DC_WORD_W      64
`define DC_LINE_WORDS  4   // words per line.

//////////////////////////////
// geometry
//////////////////////////////
`define DC_LINES       16
`define DC_OFFSET_W    5   // byte offset within a line.
`define DC_INDEX_W     4
`define DC_TAG_W       23  // addr minus index and offset.

`endif

// ==== rtl/dcache_pkg.sv ====
`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0]                addr_t;
    typedef logic [`DC_WORD_W-1:0]                word_t;
    typedef logic [`DC_WORD_W/8-1:0]              strb_t;
    typedef logic [`DC_WORD_W*`DC_LINE_WORDS-1:0] line_t;
    typedef logic [`DC_ADDR_W-`DC_OFFSET_W-1:0]   line_addr_t;  // as seen by L2.
    typedef logic [`DC_INDEX_W-1:0]               index_t;
    typedef logic [`DC_TAG_W-1:0]                 tag_t;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE,
        MEM_AMO
    } mem_op_e;

    // AMO_PLAIN leaves the word as it was.
    typedef enum logic [3:0] {
        AMO_PLAIN, AMO_SWAP, AMO_ADD, AMO_XOR, AMO_OR,
        AMO_AND, AMO_MIN, AMO_MAX, AMO_MINU, AMO_MAXU
    } amo_op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,  // victim pulse to L2.
        ST_WB_WAIT,
        ST_REFILL,     // read pulse to L2.
        ST_RF_WAIT
    } ctrl_state_e;

endpackage

// ==== rtl/cache_arrays.sv ====
`timescale 1ns/100ps
`include "dcache_macros.svh"

module cache_arrays (
    input  logic               CLK,
    input  logic               RST,
    input  dcache_pkg::index_t rd_index,
    input  logic               wr_en,
    input  dcache_pkg::index_t wr_index,
    input  dcache_pkg::line_t  wr_line,
    input  dcache_pkg::tag_t   wr_tag,
    input  logic               wr_valid,
    input  logic               wr_dirty,
    output dcache_pkg::line_t  rd_line,
    output dcache_pkg::tag_t   rd_tag,
    output logic               rd_valid,
    output logic               rd_dirty
);

    dcache_pkg::line_t    line_mem  [`DC_LINES];
    dcache_pkg::tag_t     tag_mem   [`DC_LINES];
    logic                 dirty_mem [`DC_LINES];
    logic [`DC_LINES-1:0] valid_q;
    logic                 fwd;

    // same-edge write to the index being read.
    assign fwd = wr_en && (wr_index == rd_index);

    //////////////////////////////
    // line, tag and dirty storage
    //////////////////////////////
    always_ff @(posedge CLK) begin
        if (wr_en) begin
            line_mem[wr_index]  <= wr_line;
            tag_mem[wr_index]   <= wr_tag;
            dirty_mem[wr_index] <= wr_dirty;
        end
        rd_line  <= fwd ? wr_line  : line_mem[rd_index];
        rd_tag   <= fwd ? wr_tag   : tag_mem[rd_index];
        rd_dirty <= fwd ? wr_dirty : dirty_mem[rd_index];
    end

    //////////////////////////////
    // valid bits
    //////////////////////////////
    always_ff @(posedge CLK) begin
        if (RST) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_index] <= wr_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= fwd ? wr_valid : valid_q[rd_index];  // bypass the fresh entry.
        end
    end

    // every write needs a known index.
    wr_index_known: assert property (
        @(posedge CLK) disable iff (RST)
        wr_en |-> !$isunknown(wr_index)
    ) else $error("cache_arrays: write with unknown index.");

endmodule

// ==== rtl/amo_unit.sv ====
`timescale 1ns/100ps
`include "dcache_macros.svh"

module amo_unit (
    input  dcache_pkg::mem_op_e op,
    input  dcache_pkg::addr_t   addr,
    input  dcache_pkg::word_t   wdata,
    input  dcache_pkg::strb_t   wstrb,
    input  dcache_pkg::amo_op_e amo,
    input  logic                op32,
    input  dcache_pkg::line_t   line,
    output dcache_pkg::word_t   old_word,
    output dcache_pkg::line_t   new_line
);

    logic [`DC_OFFSET_W-4:0] word_sel;
    logic [31:0]             old_half;
    logic [31:0]             arg_half;
    dcache_pkg::word_t       op_a;
    dcache_pkg::word_t       op_b;
    logic                    signed_lt;
    logic                    unsigned_lt;
    dcache_pkg::word_t       amo_res;
    dcache_pkg::word_t       amo_word;
    dcache_pkg::word_t       store_word;
    dcache_pkg::word_t       new_word;

    assign word_sel = addr[`DC_OFFSET_W-1:3];
    assign old_word = line[word_sel*`DC_WORD_W +: `DC_WORD_W];

    // addr[2] picks the half on a 32-bit op.
    assign old_half = addr[2] ? old_word[63:32] : old_word[31:0];
    assign arg_half = addr[2] ? wdata[63:32] : wdata[31:0];
    assign op_a     = op32 ? {32'b0, old_half} : old_word;
    assign op_b     = op32 ? {32'b0, arg_half} : wdata;

    assign unsigned_lt = op_a < op_b;
    assign signed_lt   = op32 ? ($signed(old_half) < $signed(arg_half))
                              : ($signed(old_word) < $signed(wdata));

    //////////////////////////////
    // atomic operation
    //////////////////////////////
    always_comb begin
        case (amo)
            dcache_pkg::AMO_SWAP: amo_res = op_b;
            dcache_pkg::AMO_ADD:  amo_res = op_a + op_b;
            dcache_pkg::AMO_XOR:  amo_res = op_a ^ op_b;
            dcache_pkg::AMO_OR:   amo_res = op_a | op_b;
            dcache_pkg::AMO_AND:  amo_res = op_a & op_b;
            dcache_pkg::AMO_MIN:  amo_res = signed_lt ? op_a : op_b;
            dcache_pkg::AMO_MAX:  amo_res = signed_lt ? op_b : op_a;
            dcache_pkg::AMO_MINU: amo_res = unsigned_lt ? op_a : op_b;
            dcache_pkg::AMO_MAXU: amo_res = unsigned_lt ? op_b : op_a;
            default:              amo_res = op_a;  // plain, no change.
        endcase
    end

    always_comb begin
        if (!op32) begin
            amo_word = amo_res;
        end else if (addr[2]) begin
            amo_word = {amo_res[31:0], old_word[31:0]};
        end else begin
            amo_word = {old_word[63:32], amo_res[31:0]};
        end
    end

    //////////////////////////////
    // store merge and line update
    //////////////////////////////
    always_comb begin
        for (int b = 0; b < `DC_WORD_W/8; b++) begin
            store_word[b*8 +: 8] = wstrb[b] ? wdata[b*8 +: 8] : old_word[b*8 +: 8];
        end
    end

    always_comb begin
        case (op)
            dcache_pkg::MEM_STORE: new_word = store_word;
            dcache_pkg::MEM_AMO:   new_word = amo_word;
            default:               new_word = old_word;
        endcase
        new_line = line;
        new_line[word_sel*`DC_WORD_W +: `DC_WORD_W] = new_word;  // back into its slot.
    end

endmodule

// ==== rtl/miss_controller.sv ====
`timescale 1ns/100ps
`include "dcache_macros.svh"

module miss_controller (
    input  logic                   CLK,
    input  logic                   RST,
    input  logic                   req_valid,
    input  dcache_pkg::mem_op_e    req_op,
    input  dcache_pkg::addr_t      req_addr,
    input  dcache_pkg::word_t      req_wdata,
    input  dcache_pkg::strb_t      req_wstrb,
    input  dcache_pkg::amo_op_e    req_amo,
    input  logic                   req_op32,
    input  dcache_pkg::tag_t       rd_tag,
    input  logic                   rd_valid,
    input  logic                   rd_dirty,
    input  dcache_pkg::line_t      rd_line,
    input  dcache_pkg::line_t      new_line,
    input  dcache_pkg::word_t      old_word,
    input  logic                   l2_rd_done,
    input  dcache_pkg::line_t      l2_rd_data,
    input  logic                   l2_wr_done,
    output logic                   ready,
    output logic                   resp_valid,
    output dcache_pkg::word_t      resp_data,
    output dcache_pkg::index_t     rd_index,
    output logic                   wr_en,
    output dcache_pkg::index_t     wr_index,
    output dcache_pkg::line_t      wr_line,
    output dcache_pkg::tag_t       wr_tag,
    output logic                   wr_valid,
    output logic                   wr_dirty,
    output dcache_pkg::mem_op_e    op,
    output dcache_pkg::addr_t      addr,
    output dcache_pkg::word_t      wdata,
    output dcache_pkg::strb_t      wstrb,
    output dcache_pkg::amo_op_e    amo,
    output logic                   op32,
    output logic                   l2_rd_valid,
    output dcache_pkg::line_addr_t l2_rd_addr,
    output logic                   l2_wr_valid,
    output dcache_pkg::line_addr_t l2_wr_addr,
    output dcache_pkg::line_t      l2_wr_data
);

    dcache_pkg::ctrl_state_e state;
    dcache_pkg::index_t      cur_index;
    dcache_pkg::tag_t        cur_tag;
    logic                    lookup_ph;  // array output is for cur_index.
    logic                    hit;
    logic                    miss;
    logic                    is_write;
    logic                    lookup_done;
    logic                    refill_done;

    assign cur_index   = addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign cur_tag     = addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign hit         = rd_valid && (rd_tag == cur_tag);
    assign miss        = (state == dcache_pkg::ST_LOOKUP) && lookup_ph && !hit;
    assign is_write    = (op == dcache_pkg::MEM_STORE) || (op == dcache_pkg::MEM_AMO);
    assign lookup_done = (state == dcache_pkg::ST_LOOKUP) && lookup_ph && hit;
    assign refill_done = (state == dcache_pkg::ST_RF_WAIT) && l2_rd_done;

    //////////////////////////////
    // request capture
    //////////////////////////////
    always_ff @(posedge CLK) begin
        if (ready && req_valid) begin
            op    <= req_op;
            addr  <= req_addr;
            wdata <= req_wdata;
            wstrb <= req_wstrb;
            amo   <= req_amo;
            op32  <= req_op32;
        end
    end

    //////////////////////////////
    // control FSM
    //////////////////////////////
    always_ff @(posedge CLK) begin
        if (RST) begin
            state       <= dcache_pkg::ST_IDLE;
            ready       <= 1'b1;
            lookup_ph   <= 1'b0;
            l2_rd_valid <= 1'b0;
            l2_wr_valid <= 1'b0;
        end else begin
            l2_rd_valid <= 1'b0;  // both valids are single pulses.
            l2_wr_valid <= 1'b0;
            case (state)
                dcache_pkg::ST_IDLE: begin
                    if (req_valid) begin
                        state     <= dcache_pkg::ST_LOOKUP;
                        ready     <= 1'b0;
                        lookup_ph <= 1'b0;  // wait for the array read.
                    end
                end
                dcache_pkg::ST_LOOKUP: begin
                    lookup_ph <= 1'b1;
                    if (lookup_done) begin
                        state <= dcache_pkg::ST_IDLE;
                        ready <= 1'b1;
                    end else if (miss && rd_valid && rd_dirty) begin
                        state       <= dcache_pkg::ST_WRITEBACK;
                        l2_wr_valid <= 1'b1;
                    end else if (miss) begin
                        state       <= dcache_pkg::ST_REFILL;
                        l2_rd_valid <= 1'b1;
                    end
                end
                dcache_pkg::ST_WRITEBACK: state <= dcache_pkg::ST_WB_WAIT;
                dcache_pkg::ST_WB_WAIT: begin
                    if (l2_wr_done) begin
                        state       <= dcache_pkg::ST_REFILL;
                        l2_rd_valid <= 1'b1;
                    end
                end
                dcache_pkg::ST_REFILL: state <= dcache_pkg::ST_RF_WAIT;
                dcache_pkg::ST_RF_WAIT: begin
                    if (l2_rd_done) begin
                        state     <= dcache_pkg::ST_LOOKUP;
                        lookup_ph <= 1'b1;  // arrays forward the installed line.
                    end
                end
                default: state <= dcache_pkg::ST_IDLE;
            endcase
        end
    end

    // victim held for the writeback pulse.
    always_ff @(posedge CLK) begin
        if (miss) begin
            l2_wr_addr <= {rd_tag, cur_index};
            l2_wr_data <= rd_line;
        end
    end

    assign l2_rd_addr = addr[`DC_ADDR_W-1:`DC_OFFSET_W];

    //////////////////////////////
    // array and response side
    //////////////////////////////
    assign rd_index   = cur_index;
    assign wr_en      = (lookup_done && is_write) || refill_done;
    assign wr_index   = cur_index;
    assign wr_tag     = cur_tag;
    assign wr_line    = refill_done ? l2_rd_data : new_line;
    assign wr_valid   = 1'b1;
    assign wr_dirty   = !refill_done;  // refill installs clean.
    assign resp_valid = lookup_done;
    assign resp_data  = old_word;

    l2_one_request: assert property (
        @(posedge CLK) disable iff (RST)
        !(l2_rd_valid && l2_wr_valid)
    ) else $error("miss_controller: L2 read and write issued together.");

    ready_only_idle: assert property (
        @(posedge CLK) disable iff (RST)
        ready |-> (state == dcache_pkg::ST_IDLE)
    ) else $error("miss_controller: ready outside idle.");

endmodule

// ==== rtl/dcache_top.sv ====
`timescale 1ns/100ps

module dcache_top (
    input  logic                   CLK,
    input  logic                   RST,
    input  logic                   req_valid,
    input  dcache_pkg::mem_op_e    req_op,
    input  dcache_pkg::addr_t      req_addr,
    input  dcache_pkg::word_t      req_wdata,
    input  dcache_pkg::strb_t      req_wstrb,
    input  dcache_pkg::amo_op_e    req_amo,
    input  logic                   req_op32,
    input  logic                   l2_rd_done,
    input  dcache_pkg::line_t      l2_rd_data,
    input  logic                   l2_wr_done,
    output logic                   ready,
    output logic                   resp_valid,
    output dcache_pkg::word_t      resp_data,
    output logic                   l2_rd_valid,
    output dcache_pkg::line_addr_t l2_rd_addr,
    output logic                   l2_wr_valid,
    output dcache_pkg::line_addr_t l2_wr_addr,
    output dcache_pkg::line_t      l2_wr_data
);

    // array read side
    dcache_pkg::index_t  rd_index;
    dcache_pkg::line_t   rd_line;
    dcache_pkg::tag_t    rd_tag;
    logic                rd_valid;
    logic                rd_dirty;

    // array write side
    logic                wr_en;
    dcache_pkg::index_t  wr_index;
    dcache_pkg::line_t   wr_line;
    dcache_pkg::tag_t    wr_tag;
    logic                wr_valid;
    logic                wr_dirty;

    // captured request and merge result
    dcache_pkg::mem_op_e cur_op;
    dcache_pkg::addr_t   cur_addr;
    dcache_pkg::word_t   cur_wdata;
    dcache_pkg::strb_t   cur_wstrb;
    dcache_pkg::amo_op_e cur_amo;
    logic                cur_op32;
    dcache_pkg::line_t   new_line;
    dcache_pkg::word_t   old_word;

    cache_arrays arrays_inst (
        .CLK      (CLK),      .RST      (RST),
        .rd_index (rd_index), .wr_en    (wr_en),
        .wr_index (wr_index), .wr_line  (wr_line),
        .wr_tag   (wr_tag),   .wr_valid (wr_valid),
        .wr_dirty (wr_dirty), .rd_line  (rd_line),
        .rd_tag   (rd_tag),   .rd_valid (rd_valid),
        .rd_dirty (rd_dirty)
    );

    miss_controller ctrl_inst (
        .CLK        (CLK),         .RST         (RST),
        .req_valid  (req_valid),   .req_op      (req_op),
        .req_addr   (req_addr),    .req_wdata   (req_wdata),
        .req_wstrb  (req_wstrb),   .req_amo     (req_amo),
        .req_op32   (req_op32),    .rd_tag      (rd_tag),
        .rd_valid   (rd_valid),    .rd_dirty    (rd_dirty),
        .rd_line    (rd_line),     .new_line    (new_line),
        .old_word   (old_word),    .l2_rd_done  (l2_rd_done),
        .l2_rd_data (l2_rd_data),  .l2_wr_done  (l2_wr_done),
        .ready      (ready),       .resp_valid  (resp_valid),
        .resp_data  (resp_data),   .rd_index    (rd_index),
        .wr_en      (wr_en),       .wr_index    (wr_index),
        .wr_line    (wr_line),     .wr_tag      (wr_tag),
        .wr_valid   (wr_valid),    .wr_dirty    (wr_dirty),
        .op         (cur_op),      .addr        (cur_addr),
        .wdata      (cur_wdata),   .wstrb       (cur_wstrb),
        .amo        (cur_amo),     .op32        (cur_op32),
        .l2_rd_valid(l2_rd_valid), .l2_rd_addr  (l2_rd_addr),
        .l2_wr_valid(l2_wr_valid), .l2_wr_addr  (l2_wr_addr),
        .l2_wr_data (l2_wr_data)
    );

    amo_unit amo_inst (
        .op       (cur_op),    .addr     (cur_addr),
        .wdata    (cur_wdata), .wstrb    (cur_wstrb),
        .amo      (cur_amo),   .op32     (cur_op32),
        .line     (rd_line),   .old_word (old_word),
        .new_line (new_line)
    );

endmodule

// ==== testbench/dcache_checker.sv ====
`timescale 1ns/100ps
`include "dcache_macros.svh"

module dcache_checker (
    input  logic                   CLK,
    input  logic                   RST,
    input  logic                   req_valid,
    input  dcache_pkg::mem_op_e    req_op,
    input  dcache_pkg::addr_t      req_addr,
    input  dcache_pkg::word_t      req_wdata,
    input  dcache_pkg::strb_t      req_wstrb,
    input  dcache_pkg::amo_op_e    req_amo,
    input  logic                   req_op32,
    input  logic                   ready,
    input  logic                   resp_valid,
    input  dcache_pkg::word_t      resp_data,
    input  logic                   l2_rd_valid,
    input  dcache_pkg::line_addr_t l2_rd_addr,
    input  logic                   l2_wr_valid,
    input  dcache_pkg::line_addr_t l2_wr_addr,
    input  dcache_pkg::line_t      l2_wr_data,
    input  logic                   exp_hit,
    input  logic                   exp_wb,
    input  int                     test_id,
    output int                     errors,
    output int                     tests
);

    dcache_pkg::word_t      shadow [dcache_pkg::addr_t];
    dcache_pkg::word_t      exp_data;
    dcache_pkg::word_t      exp_word;
    dcache_pkg::line_addr_t exp_line;
    dcache_pkg::addr_t      wb_addr;
    logic                   in_flight;
    logic                   cur_hit;
    logic                   cur_wb;
    logic                   saw_rd;
    logic                   saw_wr;
    logic                   test_bad;
    int                     cyc;
    int                     accept_cyc;
    int                     cur_id;

    initial begin
        errors    = 0;
        tests     = 0;
        cyc       = 0;
        in_flight = 1'b0;
    end

    // untouched memory holds its own byte address in both halves.
    function automatic dcache_pkg::word_t shadow_read(dcache_pkg::addr_t a);
        dcache_pkg::addr_t wa;
        wa = {a[31:3], 3'b000};
        if (shadow.exists(wa)) begin
            return shadow[wa];
        end
        return {wa, wa};
    endfunction

    function automatic dcache_pkg::word_t merge_word(
        dcache_pkg::mem_op_e op, dcache_pkg::amo_op_e amo, logic op32, logic hi,
        dcache_pkg::word_t old, dcache_pkg::word_t arg, dcache_pkg::strb_t strb);
        dcache_pkg::word_t a;
        dcache_pkg::word_t b;
        dcache_pkg::word_t r;
        dcache_pkg::word_t res;
        logic [31:0]       a32;
        logic [31:0]       b32;
        logic              sx;
        sx  = (amo == dcache_pkg::AMO_MIN) || (amo == dcache_pkg::AMO_MAX);
        a32 = hi ? old[63:32] : old[31:0];
        b32 = hi ? arg[63:32] : arg[31:0];
        if (op32) begin
            a = sx ? {{32{a32[31]}}, a32} : {32'b0, a32};  // extend for the compare.
            b = sx ? {{32{b32[31]}}, b32} : {32'b0, b32};
        end else begin
            a = old;
            b = arg;
        end
        case (amo)
            dcache_pkg::AMO_SWAP: r = b;
            dcache_pkg::AMO_ADD:  r = a + b;
            dcache_pkg::AMO_XOR:  r = a ^ b;
            dcache_pkg::AMO_OR:   r = a | b;
            dcache_pkg::AMO_AND:  r = a & b;
            dcache_pkg::AMO_MIN:  r = ($signed(a) < $signed(b)) ? a : b;
            dcache_pkg::AMO_MAX:  r = ($signed(a) < $signed(b)) ? b : a;
            dcache_pkg::AMO_MINU: r = (a < b) ? a : b;
            dcache_pkg::AMO_MAXU: r = (a < b) ? b : a;
            default:              r = a;
        endcase
        if (op32) begin
            res = hi ? {r[31:0], old[31:0]} : {old[63:32], r[31:0]};
        end else begin
            res = r;
        end
        if (op == dcache_pkg::MEM_STORE) begin
            for (int i = 0; i < 8; i++) begin
                res[i*8 +: 8] = strb[i] ? arg[i*8 +: 8] : old[i*8 +: 8];
            end
        end else if (op != dcache_pkg::MEM_AMO) begin
            res = old;
        end
        return res;
    endfunction

    task automatic value_error(string msg);
        $display("FAIL @ %0t: test %0d: %s", $time, cur_id, msg);
        errors   = errors + 1;
        test_bad = 1'b1;
    endtask

    task automatic protocol_error(string msg);
        $display("Test %0d went wrong: %s.", cur_id, msg);
        errors   = errors + 1;
        test_bad = 1'b1;
    endtask

    //////////////////////////////
    // request and response watch
    //////////////////////////////
    always @(posedge CLK) begin
        cyc = cyc + 1;
        if (RST) begin
            in_flight = 1'b0;
        end else if (ready && req_valid) begin
            in_flight  = 1'b1;
            accept_cyc = cyc;
            cur_id     = test_id;
            cur_hit    = exp_hit;
            cur_wb     = exp_wb;
            saw_rd     = 1'b0;
            saw_wr     = 1'b0;
            test_bad   = 1'b0;
            exp_line   = req_addr[31:5];
            exp_data   = shadow_read(req_addr);
            shadow[{req_addr[31:3], 3'b000}] = merge_word(req_op, req_amo, req_op32,
                req_addr[2], exp_data, req_wdata, req_wstrb);
        end else if (in_flight) begin
            if (ready) begin
                protocol_error("ready went high before the response");
            end
            if (l2_wr_valid) begin
                saw_wr = 1'b1;
                if (saw_rd) begin
                    protocol_error("the writeback came after the refill read");
                end
                for (int w = 0; w < `DC_LINE_WORDS; w++) begin
                    wb_addr  = {l2_wr_addr, 5'(w * 8)};
                    exp_word = shadow_read(wb_addr);
                    if (l2_wr_data[w*64 +: 64] != exp_word) begin
                        value_error($sformatf("writeback word %0d is %h, expected %h",
                            w, l2_wr_data[w*64 +: 64], exp_word));
                    end
                end
            end
            if (l2_rd_valid) begin
                saw_rd = 1'b1;
                if (l2_rd_addr != exp_line) begin
                    value_error($sformatf("refill address %h, expected %h",
                        l2_rd_addr, exp_line));
                end
            end
            if (resp_valid) begin
                if (resp_data != exp_data) begin
                    value_error($sformatf("response %h, expected %h", resp_data, exp_data));
                end
                if (cur_hit && (saw_rd || (cyc - accept_cyc) != 2)) begin
                    protocol_error("a hit did not answer two cycles after acceptance");
                end
                if (!cur_hit && !saw_rd) begin
                    protocol_error("an expected miss issued no L2 read");
                end
                if (saw_wr != cur_wb) begin
                    protocol_error("the writeback did not happen as expected");
                end
                tests = tests + 1;
                $display("test %0d: %s", cur_id, test_bad ? "failed" : "passed");
                in_flight = 1'b0;
            end
        end else if (!ready || resp_valid || l2_rd_valid || l2_wr_valid) begin
            protocol_error("the cache was not idle and ready between requests");
        end
    end

endmodule

// ==== testbench/dcache_tb.sv ====
`timescale 1ns/100ps
`include "dcache_macros.svh"

module dcache_tb;

    typedef struct packed {
        dcache_pkg::mem_op_e op;
        dcache_pkg::addr_t   addr;
        dcache_pkg::word_t   data;
        dcache_pkg::strb_t   strb;
        dcache_pkg::amo_op_e amo;
        logic                op32;
        logic                hit;
        logic                wb;
    } stim_t;

    logic                   CLK;
    logic                   RST;
    logic                   req_valid;
    dcache_pkg::mem_op_e    req_op;
    dcache_pkg::addr_t      req_addr;
    dcache_pkg::word_t      req_wdata;
    dcache_pkg::strb_t      req_wstrb;
    dcache_pkg::amo_op_e    req_amo;
    logic                   req_op32;
    logic                   l2_rd_done;
    dcache_pkg::line_t      l2_rd_data;
    logic                   l2_wr_done;
    logic                   ready;
    logic                   resp_valid;
    dcache_pkg::word_t      resp_data;
    logic                   l2_rd_valid;
    dcache_pkg::line_addr_t l2_rd_addr;
    logic                   l2_wr_valid;
    dcache_pkg::line_addr_t l2_wr_addr;
    dcache_pkg::line_t      l2_wr_data;

    stim_t                  stim_q [$];
    dcache_pkg::line_t      l2_mem [dcache_pkg::line_addr_t];
    dcache_pkg::line_addr_t rd_addr;
    integer                 seed;
    int                     delay;
    logic                   timed_out;
    logic                   exp_hit;
    logic                   exp_wb;
    int                     test_id;
    int                     errors;
    int                     tests;

    dcache_top dcache_top_inst (
        .CLK        (CLK),        .RST        (RST),
        .req_valid  (req_valid),  .req_op     (req_op),
        .req_addr   (req_addr),   .req_wdata  (req_wdata),
        .req_wstrb  (req_wstrb),  .req_amo    (req_amo),
        .req_op32   (req_op32),   .l2_rd_done (l2_rd_done),
        .l2_rd_data (l2_rd_data), .l2_wr_done (l2_wr_done),
        .ready      (ready),      .resp_valid (resp_valid),
        .resp_data  (resp_data),  .l2_rd_valid(l2_rd_valid),
        .l2_rd_addr (l2_rd_addr), .l2_wr_valid(l2_wr_valid),
        .l2_wr_addr (l2_wr_addr), .l2_wr_data (l2_wr_data)
    );

    dcache_checker checker_inst (
        .CLK        (CLK),        .RST        (RST),
        .req_valid  (req_valid),  .req_op     (req_op),
        .req_addr   (req_addr),   .req_wdata  (req_wdata),
        .req_wstrb  (req_wstrb),  .req_amo    (req_amo),
        .req_op32   (req_op32),   .ready      (ready),
        .resp_valid (resp_valid), .resp_data  (resp_data),
        .l2_rd_valid(l2_rd_valid), .l2_rd_addr (l2_rd_addr),
        .l2_wr_valid(l2_wr_valid), .l2_wr_addr (l2_wr_addr),
        .l2_wr_data (l2_wr_data), .exp_hit    (exp_hit),
        .exp_wb     (exp_wb),     .test_id    (test_id),
        .errors     (errors),     .tests      (tests)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic dcache_pkg::line_t pattern_line(dcache_pkg::line_addr_t la);
        dcache_pkg::line_t l;
        dcache_pkg::addr_t a;
        for (int w = 0; w < `DC_LINE_WORDS; w++) begin
            a = {la, 5'(w * 8)};
            l[w*64 +: 64] = {a, a};
        end
        return l;
    endfunction

    task automatic add_entry(dcache_pkg::mem_op_e op, dcache_pkg::addr_t addr,
        dcache_pkg::word_t data, dcache_pkg::strb_t strb, dcache_pkg::amo_op_e amo,
        logic op32, logic hit, logic wb);
        stim_q.push_back('{op, addr, data, strb, amo, op32, hit, wb});
    endtask

    //////////////////////////////
    // stimulus table
    //////////////////////////////
    task automatic build_table();
        dcache_pkg::addr_t a;
        dcache_pkg::word_t d;
        add_entry(dcache_pkg::MEM_LOAD, 32'h1000, '0, '0, dcache_pkg::AMO_PLAIN, 0, 0, 0);
        add_entry(dcache_pkg::MEM_LOAD, 32'h1008, '0, '0, dcache_pkg::AMO_PLAIN, 0, 1, 0);
        add_entry(dcache_pkg::MEM_STORE, 32'h1010, 64'h1122334455667788, 8'h0f,
            dcache_pkg::AMO_PLAIN, 0, 1, 0);
        add_entry(dcache_pkg::MEM_LOAD, 32'h1010, '0, '0, dcache_pkg::AMO_PLAIN, 0, 1, 0);
        for (int m = 0; m < 3; m++) begin  // full word, low half, high half.
            a = (m == 0) ? 32'h1018 : (m == 1) ? 32'h1000 : 32'h1004;
            for (int k = 1; k <= 9; k++) begin
                d = {$random(seed), $random(seed)};
                add_entry(dcache_pkg::MEM_AMO, a, d, '0, dcache_pkg::amo_op_e'(k),
                    m != 0, 1, 0);
                add_entry(dcache_pkg::MEM_LOAD, a, '0, '0, dcache_pkg::AMO_PLAIN, 0, 1, 0);
            end
        end
        add_entry(dcache_pkg::MEM_LOAD, 32'h3000, '0, '0, dcache_pkg::AMO_PLAIN, 0, 0, 1);
        add_entry(dcache_pkg::MEM_LOAD, 32'h1010, '0, '0, dcache_pkg::AMO_PLAIN, 0, 0, 0);
        add_entry(dcache_pkg::MEM_LOAD, 32'h1010, '0, '0, dcache_pkg::AMO_PLAIN, 0, 1, 0);
        add_entry(dcache_pkg::MEM_STORE, 32'h2024, 64'hdeadbeefcafef00d, 8'hf0,
            dcache_pkg::AMO_PLAIN, 0, 0, 0);
        add_entry(dcache_pkg::MEM_LOAD, 32'h2020, '0, '0, dcache_pkg::AMO_PLAIN, 0, 1, 0);
    endtask

    //////////////////////////////
    // L2 model
    //////////////////////////////
    initial begin
        l2_rd_done = 1'b0;
        l2_wr_done = 1'b0;
        l2_rd_data = '0;
        forever begin
            @(negedge CLK);
            l2_rd_done = 1'b0;  // done is a one-cycle pulse.
            l2_wr_done = 1'b0;
            if (l2_wr_valid) begin
                l2_mem[l2_wr_addr] = l2_wr_data;
                delay = 1 + ($unsigned($random(seed)) % 6);
                repeat (delay) @(negedge CLK);
                l2_wr_done = 1'b1;
            end else if (l2_rd_valid) begin
                rd_addr = l2_rd_addr;
                delay   = 1 + ($unsigned($random(seed)) % 6);
                repeat (delay) @(negedge CLK);
                l2_rd_data = l2_mem.exists(rd_addr) ? l2_mem[rd_addr] : pattern_line(rd_addr);
                l2_rd_done = 1'b1;
            end
        end
    end

    task automatic wait_for_ready();
        int n;
        n = 0;
        while (!ready && n < 200) begin
            @(negedge CLK);
            n++;
        end
        if (!ready) begin
            timed_out = 1'b1;
            $display("Timeout: the cache did not become ready within 200 cycles.");
        end
    endtask

    task automatic wait_for_response();
        int n;
        n = 0;
        while (!resp_valid && n < 200) begin
            @(negedge CLK);
            n++;
        end
        if (!resp_valid) begin
            timed_out = 1'b1;
            $display("Timeout: no response arrived within 200 cycles.");
        end
    endtask

    initial begin
        RST       = 1'b1;
        req_valid = 1'b0;
        req_op    = dcache_pkg::MEM_NONE;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        req_amo   = dcache_pkg::AMO_PLAIN;
        req_op32  = 1'b0;
        exp_hit   = 1'b0;
        exp_wb    = 1'b0;
        test_id   = 0;
        timed_out = 1'b0;
        seed      = 75;
        build_table();
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;
        for (int i = 0; i < stim_q.size(); i++) begin
            wait_for_ready();
            if (timed_out) break;
            test_id   = i;
            exp_hit   = stim_q[i].hit;
            exp_wb    = stim_q[i].wb;
            req_op    = stim_q[i].op;
            req_addr  = stim_q[i].addr;
            req_wdata = stim_q[i].data;
            req_wstrb = stim_q[i].strb;
            req_amo   = stim_q[i].amo;
            req_op32  = stim_q[i].op32;
            req_valid = 1'b1;
            @(negedge CLK);
            req_valid = 1'b0;  // accepted at the edge just past.
            wait_for_response();
            if (timed_out) break;
        end
        @(negedge CLK);
        $display("%0d of %0d tests run, %0d errors", tests, stim_q.size(), errors);
        if (timed_out || errors != 0 || tests != stim_q.size()) begin
            $display("SOME TESTS FAILED");
        end else begin
            $display("ALL TESTS PASSED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
rtl/dcache_pkg.sv
rtl/cache_arrays.sv
rtl/amo_unit.sv
rtl/miss_controller.sv
rtl/dcache_top.sv
testbench/dcache_checker.sv
testbench/dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= dcache_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ALL TESTS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
